//--- Makefile
VERILATOR ?= verilator
TOP       ?= aluClusterTb
FILELIST  ?= all.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary -j 0
PASSTEXT  ?= ALL TESTS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST OBJDIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASSTEXT)"

clean:
	rm -rf $(OBJDIR)

//--- all.f
+incdir+.
aluPkg.sv
aluLaneIf.sv
shifter16.sv
alu.sv
aluLane.sv
wbDispatcher.sv
resultCollector.sv
aluCluster.sv
tbClock.sv
tbChecker.sv
aluClusterTb.sv

//--- alu.sv
`timescale 1ns/1ps
`include "alu_macros.svh"

module alu import aluPkg::*; (
   input  logic [`ALU_WIDTH-1:0] a,
   input  logic [`ALU_WIDTH-1:0] b,
   input  aluOp_t                op,
   input  logic                  sign,
   output logic [`ALU_WIDTH-1:0] result,
   output logic                  ofl,
   output logic                  zero
);
   localparam int W = `ALU_WIDTH;

   logic [W-1:0] opA;
   logic [W-1:0] opB;
   logic         cin;
   logic [W-1:0] sum;
   logic         carry;
   logic         oflSigned;
   logic         oflUnsigned;
   logic         isSub;
   logic         isArith;
   logic         eq;
   logic         less;
   logic [W-1:0] shiftOut;

   // SUB is B minus A by swapping and inverting A
   assign isSub = (op == SUB);
   assign opA   = isSub ? b : a;
   assign opB   = isSub ? ~a : b;
   assign cin   = isSub;

   assign {carry, sum} = {1'b0, opA} + {1'b0, opB} + {{W{1'b0}}, cin};

   // Two like signs giving the other sign
   assign oflSigned = (opA[W-1] & opB[W-1] & ~sum[W-1]) |
                      (~opA[W-1] & ~opB[W-1] & sum[W-1]);
   assign oflUnsigned = isSub ? ~carry : carry;  // Borrow is missing carry
   assign isArith     = (op == ADD) || isSub;
   assign ofl         = isArith & (sign ? oflSigned : oflUnsigned);

   assign eq   = (a == b);
   assign less = sign ? ($signed(a) < $signed(b)) : (a < b);

   // Low two op bits give the shift mode for ROL..SRA
   shifter16 uShifter (
      .in     (a),
      .amount (b[3:0]),
      .mode   (shiftMode_t'(op[1:0])),
      .out    (shiftOut)
   );

   always_comb begin
      case (op)
         ADD, SUB:           result = sum;
         OR:                 result = opA | opB;
         AND:                result = opA & opB;
         ROL, SLL, ROR, SRA: result = shiftOut;
         BTR:                result = {<<{a}};
         SEQ:                result = {{(W-1){1'b0}}, eq};
         SLT:                result = {{(W-1){1'b0}}, less};
         SLE:                result = {{(W-1){1'b0}}, less | eq};
         SCO:                result = {{(W-1){1'b0}}, carry};  // Carry of A plus B
         LBI:                result = b;
         SLBI:               result = {a[7:0], 8'b0} | b;
         default:            result = '0;
      endcase
   end

   assign zero = (result == '0);

endmodule

//--- aluCluster.sv
`timescale 1ns/1ps
`include "alu_macros.svh"

module aluCluster import aluPkg::*; (
   input  logic                  clk,
   input  logic                  rstN,
   input  logic                  wbCyc,
   input  logic                  wbStb,
   input  logic                  wbWe,
   input  logic [`ADR_WIDTH-1:0] wbAdr,
   input  logic [`BUS_WIDTH-1:0] wbDatW,
   output logic [`BUS_WIDTH-1:0] wbDatR,
   output logic                  wbAck
);
   logic                         capture;
   logic [`LANE_MSB-`LANE_LSB:0] selLane;
   laneReg_t                     selReg;

   aluLaneIf laneIf [`ALU_LANES] ();

   wbDispatcher uDispatch (
      .clk     (clk),
      .rstN    (rstN),
      .wbCyc   (wbCyc),
      .wbStb   (wbStb),
      .wbWe    (wbWe),
      .wbAdr   (wbAdr),
      .wbDatW  (wbDatW),
      .wbAck   (wbAck),
      .lanes   (laneIf),
      .capture (capture),
      .selLane (selLane),
      .selReg  (selReg)
   );

   for (genvar i = 0; i < `ALU_LANES; i++) begin : gLane
      aluLane uLane (
         .clk    (clk),
         .rstN   (rstN),
         .laneIf (laneIf[i])
      );
   end

   resultCollector uCollect (
      .clk     (clk),
      .rstN    (rstN),
      .capture (capture),
      .selLane (selLane),
      .selReg  (selReg),
      .lanes   (laneIf),
      .wbDatR  (wbDatR)
   );

endmodule

//--- aluClusterTb.sv
`timescale 1ns/1ps
`include "alu_macros.svh"

module aluClusterTb import aluPkg::*; ();
   localparam int resetCycles = 10;
   localparam int ackLimit    = 8;     // Samples before ack counts as missing
   localparam int nArith      = 32;    // Cases of four transactions each
   localparam int nLogic      = 80;
   localparam int nCmp        = 72;
   localparam int nRandom     = 400;
   localparam int numTxn      = 8 + 4 * (nArith + nLogic + nCmp) + nRandom + 28;
   localparam int cycleLimit  = numTxn * 4 + resetCycles + 100;

   logic                  clk;
   logic                  rstN;
   logic                  wbCyc;
   logic                  wbStb;
   logic                  wbWe;
   logic [`ADR_WIDTH-1:0] wbAdr;
   logic [`BUS_WIDTH-1:0] wbDatW;
   logic [`BUS_WIDTH-1:0] wbDatR;
   logic                  wbAck;
   int                    errCount;
   int                    checkCount;
   int                    busFails  = 0;
   int                    testsRun  = 0;
   int                    testsOk   = 0;
   int                    caseCount = 0;
   int                    cycles    = 0;
   logic [31:0]           rngState  = 32'h8726;
   aluOp_t                validOps [15] = '{ADD, SUB, OR, AND, ROL, SLL, ROR, SRA,
                                            BTR, SEQ, SLT, SLE, SCO, LBI, SLBI};

   tbClock #(.resetCycles(resetCycles)) uClock (.clk(clk), .rstN(rstN));

   aluCluster UUT (
      .clk    (clk),
      .rstN   (rstN),
      .wbCyc  (wbCyc),
      .wbStb  (wbStb),
      .wbWe   (wbWe),
      .wbAdr  (wbAdr),
      .wbDatW (wbDatW),
      .wbDatR (wbDatR),
      .wbAck  (wbAck)
   );

   tbChecker uCheck (
      .clk        (clk),
      .rstN       (rstN),
      .wbCyc      (wbCyc),
      .wbStb      (wbStb),
      .wbWe       (wbWe),
      .wbAdr      (wbAdr),
      .wbDatW     (wbDatW),
      .wbDatR     (wbDatR),
      .wbAck      (wbAck),
      .errCount   (errCount),
      .checkCount (checkCount)
   );

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [31:0] nextRand();
      rngState = xorshift(rngState);
      return rngState;
   endfunction

   // Wishbone classic transfer held until ack
   task automatic busCycle(input logic we, input logic [1:0] lane, input logic [1:0] idx,
                           input logic [31:0] data);
      int waits;
      waits = 0;
      @(posedge clk);
      wbCyc  <= 1'b1;
      wbStb  <= 1'b1;
      wbWe   <= we;
      wbAdr  <= {lane, idx, 2'b00};
      wbDatW <= data;
      do begin
         @(negedge clk);
         waits++;
      end while (!wbAck && waits < ackLimit);
      if (!wbAck) begin
         $display("lane %0d register %0d gave no ack within %0d cycles", lane, idx, ackLimit);
         busFails++;
      end else if (waits != 2) begin
         $display("ack for lane %0d came after %0d cycles where two were due", lane, waits);
         busFails++;
      end
      @(posedge clk);
      wbCyc <= 1'b0;
      wbStb <= 1'b0;
      wbWe  <= 1'b0;
   endtask

   // Load, start and read back one ALU operation on lanes 0 to 2
   task automatic runCase(input logic [15:0] a, input logic [15:0] b, input logic [4:0] op,
                          input logic sign);
      logic [1:0] lane;
      lane = 2'(caseCount % 3);
      caseCount++;
      busCycle(1'b1, lane, REG_A, {16'h0, a});
      busCycle(1'b1, lane, REG_B, {16'h0, b});
      busCycle(1'b1, lane, REG_CTRL, {26'h0, sign, op});
      busCycle(1'b0, lane, REG_RESULT, 32'h0);
   endtask

   task automatic reportTest(input string name, input int errBefore);
      int failures;
      failures = errCount + busFails - errBefore;
      testsRun++;
      if (failures == 0) begin
         testsOk++;
         $display("test %s: ok", name);
      end else begin
         $display("test %s: %0d failures", name, failures);
      end
   endtask

   initial begin
      int          errBefore;
      int          opIdx;
      logic [31:0] r;
      logic [31:0] s;
      logic [15:0] a;
      logic [15:0] b;
      logic [1:0]  lane;
      logic [1:0]  idx;
      logic        we;
      wbCyc  = 1'b0;
      wbStb  = 1'b0;
      wbWe   = 1'b0;
      wbAdr  = '0;
      wbDatW = '0;
      wait (rstN === 1'b1);

      errBefore = errCount + busFails;
      for (int i = 0; i < 4; i++) begin
         busCycle(1'b0, 2'(i), REG_RESULT, 32'h0);
         busCycle(1'b0, 2'(i), REG_CTRL, 32'h0);
      end
      reportTest("reset", errBefore);

      errBefore = errCount + busFails;
      runCase(16'h0003, 16'h0005, SUB, 1'b0);   // B minus A
      runCase(16'h1234, 16'h1234, SUB, 1'b1);   // Equal operands give zero
      runCase(16'hFFFF, 16'h0001, ADD, 1'b0);   // Unsigned carry
      runCase(16'h7FFF, 16'h0001, ADD, 1'b1);
      runCase(16'h8000, 16'h8000, ADD, 1'b1);
      runCase(16'h0001, 16'h8000, SUB, 1'b1);   // Most negative minus one
      runCase(16'h0001, 16'h0000, SUB, 1'b0);   // Borrow
      runCase(16'h0000, 16'h0000, ADD, 1'b0);
      for (int i = 0; i < nArith - 8; i++) begin
         r = nextRand();
         s = nextRand();
         runCase(r[15:0], r[31:16], s[0] ? SUB : ADD, s[1]);
      end
      reportTest("add/sub", errBefore);

      errBefore = errCount + busFails;
      for (int i = 0; i < 16; i++) begin
         r = nextRand();
         runCase(r[15:0], r[31:16], (i < 8) ? OR : AND, r[7]);
      end
      for (int m = 0; m < 4; m++) begin
         for (int n = 0; n < 16; n++) begin
            r = nextRand();
            runCase(r[15:0], {r[27:16], 4'(n)}, validOps[4 + m], r[28]);
         end
      end
      reportTest("logic/shift", errBefore);

      errBefore = errCount + busFails;
      for (int sg = 0; sg < 2; sg++) begin
         for (int k = 0; k < 3; k++) begin
            for (int i = 0; i < 8; i++) begin
               r = nextRand();
               a = r[15:0];
               b = r[31:16];
               if (i < 2) begin
                  b = a;
               end else if (i < 4) begin
                  a = {1'b1, a[14:0]};   // Signed and unsigned order differ
                  b = {1'b0, b[14:0]};
                  if (i == 3) {a, b} = {b, a};
               end
               runCase(a, b, validOps[9 + k], sg[0]);
            end
         end
      end
      for (int k = 0; k < 4; k++) begin
         opIdx = (k == 0) ? 8 : 11 + k;   // BTR, SCO, LBI, SLBI
         for (int i = 0; i < 6; i++) begin
            r = nextRand();
            runCase(r[15:0], r[31:16], validOps[opIdx], r[i]);
         end
      end
      reportTest("compare/immediate", errBefore);

      // Lane 3 is kept unstarted here
      errBefore = errCount + busFails;
      for (int i = 0; i < nRandom; i++) begin
         r    = nextRand();
         s    = nextRand();
         lane = r[1:0];
         idx  = r[3:2];
         we   = r[4];
         if (lane == 2'd3 && idx == REG_CTRL) we = 1'b0;
         if (idx == REG_CTRL) begin
            opIdx = int'(r[15:12]) % 15;
            s[4:0] = r[6] ? r[11:7] : validOps[opIdx];   // Unused codes too
            s[5]   = r[5];
         end
         busCycle(we, lane, idx, s);
      end
      reportTest("random", errBefore);

      errBefore = errCount + busFails;
      for (int i = 0; i < 4; i++) busCycle(1'b1, 2'(i), REG_A, nextRand());
      for (int i = 0; i < 4; i++) busCycle(1'b1, 2'(3 - i), REG_B, nextRand());
      for (int i = 0; i < 4; i++) begin
         r     = nextRand();
         opIdx = int'(r[11:8]) % 15;
         busCycle(1'b1, 2'((i + 1) % 4), REG_CTRL, {26'h0, r[0], validOps[opIdx]});
      end
      for (int i = 0; i < 4; i++) begin
         busCycle(1'b0, 2'(3 - i), REG_A, 32'h0);
         busCycle(1'b0, 2'(3 - i), REG_B, 32'h0);
         busCycle(1'b0, 2'(3 - i), REG_CTRL, 32'h0);
         busCycle(1'b0, 2'(3 - i), REG_RESULT, 32'h0);
      end
      reportTest("lanes", errBefore);

      $display("%0d of %0d tests ok, %0d checks, %0d data errors, %0d bus failures",
               testsOk, testsRun, checkCount, errCount, busFails);
      if (errCount == 0 && busFails == 0 && checkCount > 0 && testsOk == testsRun) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= cycleLimit) begin
         $display("timeout after %0d cycles, the test sequence did not finish", cycles);
         $display("SOME TESTS FAILED");
         $finish;
      end
   end

endmodule

//--- aluLane.sv
`timescale 1ns/1ps
`include "alu_macros.svh"

module aluLane (
   input logic    clk,
   input logic    rstN,
   aluLaneIf.lane laneIf
);
   logic [`ALU_WIDTH-1:0] aluResult;
   logic                  aluOfl;
   logic                  aluZero;
   logic                  pending;  // Result due at the next edge

   alu uAlu (
      .a      (laneIf.a),
      .b      (laneIf.b),
      .op     (laneIf.op),
      .sign   (laneIf.sign),
      .result (aluResult),
      .ofl    (aluOfl),
      .zero   (aluZero)
   );

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         laneIf.a      <= '0;
         laneIf.b      <= '0;
         laneIf.result <= '0;
         laneIf.ofl    <= 1'b0;
         laneIf.zero   <= 1'b0;
         laneIf.done   <= 1'b0;
         pending       <= 1'b0;
      end else begin
         if (laneIf.loadA) laneIf.a <= laneIf.wdata;
         if (laneIf.loadB) laneIf.b <= laneIf.wdata;
         pending <= laneIf.start;
         if (laneIf.start) begin
            laneIf.done <= 1'b0;   // Cleared at the start edge
         end else if (pending) begin
            laneIf.result <= aluResult;
            laneIf.ofl    <= aluOfl;
            laneIf.zero   <= aluZero;
            laneIf.done   <= 1'b1;
         end
      end
   end

endmodule

//--- aluLaneIf.sv
`timescale 1ns/1ps
`include "alu_macros.svh"

interface aluLaneIf import aluPkg::*; ();
   logic                  loadA;
   logic                  loadB;
   logic                  start;
   logic [`ALU_WIDTH-1:0] wdata;   // Broadcast write data
   aluOp_t                op;      // Stored CTRL fields
   logic                  sign;
   logic [`ALU_WIDTH-1:0] a;
   logic [`ALU_WIDTH-1:0] b;
   logic [`ALU_WIDTH-1:0] result;
   logic                  ofl;
   logic                  zero;
   logic                  done;

   modport dispatch (output loadA, loadB, start, wdata, op, sign);

   modport lane (input  loadA, loadB, start, wdata, op, sign,
                 output a, b, result, ofl, zero, done);

   modport collect (input a, b, op, sign, result, ofl, zero, done);
endinterface

//--- aluPkg.sv
package aluPkg;

   // ALU opcodes
   typedef enum logic [4:0] {
      ADD  = 5'd0,
      SUB  = 5'd1,
      OR   = 5'd2,
      AND  = 5'd3,
      ROL  = 5'd4,
      SLL  = 5'd5,
      ROR  = 5'd6,
      SRA  = 5'd7,
      BTR  = 5'd11,
      SEQ  = 5'd12,
      SLT  = 5'd13,
      SLE  = 5'd14,
      SCO  = 5'd15,
      LBI  = 5'd19,
      SLBI = 5'd20
   } aluOp_t;

   typedef enum logic [1:0] {
      SH_ROL = 2'd0,
      SH_SLL = 2'd1,
      SH_ROR = 2'd2,
      SH_SRA = 2'd3
   } shiftMode_t;

   // Register index inside one lane
   typedef enum logic [1:0] {
      REG_A      = 2'd0,
      REG_B      = 2'd1,
      REG_CTRL   = 2'd2,
      REG_RESULT = 2'd3
   } laneReg_t;

endpackage

//--- alu_macros.svh
`ifndef ALU_MACROS_SVH
`define ALU_MACROS_SVH

`define ALU_WIDTH 16
`define ALU_LANES 4
`define BUS_WIDTH 32
`define ADR_WIDTH 6

// Address fields above the ignored bits 1:0
`define LANE_MSB 5
`define LANE_LSB 4
`define REG_MSB  3
`define REG_LSB  2

`define SIGN_BIT 5   // Sign flag in CTRL word
`define OFL_BIT  16  // Flags above the result in RESULT word
`define ZERO_BIT 17
`define DONE_BIT 18

`endif

//--- resultCollector.sv
`timescale 1ns/1ps
`include "alu_macros.svh"

module resultCollector import aluPkg::*; (
   input  logic                         clk,
   input  logic                         rstN,
   input  logic                         capture,
   input  logic [`LANE_MSB-`LANE_LSB:0] selLane,
   input  laneReg_t                     selReg,
   aluLaneIf.collect                    lanes [`ALU_LANES],
   output logic [`BUS_WIDTH-1:0]        wbDatR
);
   logic [`BUS_WIDTH-1:0] laneWord [`ALU_LANES];

   function automatic logic [`BUS_WIDTH-1:0] packWord(
      input laneReg_t              idx,
      input logic [`ALU_WIDTH-1:0] a,
      input logic [`ALU_WIDTH-1:0] b,
      input aluOp_t                op,
      input logic                  sign,
      input logic [`ALU_WIDTH-1:0] result,
      input logic                  ofl,
      input logic                  zero,
      input logic                  done
   );
      logic [`BUS_WIDTH-1:0] w;
      w = '0;
      case (idx)
         REG_A: w[`ALU_WIDTH-1:0] = a;
         REG_B: w[`ALU_WIDTH-1:0] = b;
         REG_CTRL: begin
            w[4:0]      = op;
            w[`SIGN_BIT] = sign;
         end
         default: begin
            w[`ALU_WIDTH-1:0] = result;
            w[`OFL_BIT]       = ofl;
            w[`ZERO_BIT]      = zero;
            w[`DONE_BIT]      = done;
         end
      endcase
      return w;
   endfunction

   for (genvar i = 0; i < `ALU_LANES; i++) begin : gPack
      assign laneWord[i] = packWord(selReg, lanes[i].a, lanes[i].b, lanes[i].op,
                                    lanes[i].sign, lanes[i].result, lanes[i].ofl,
                                    lanes[i].zero, lanes[i].done);
   end

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN)        wbDatR <= '0;
      else if (capture) wbDatR <= laneWord[selLane];  // Valid while ack is high
   end

endmodule

//--- shifter16.sv
`timescale 1ns/1ps
`include "alu_macros.svh"

module shifter16 import aluPkg::*; (
   input  logic [`ALU_WIDTH-1:0] in,
   input  logic [3:0]            amount,
   input  shiftMode_t            mode,
   output logic [`ALU_WIDTH-1:0] out
);
   localparam int W = `ALU_WIDTH;

   logic [W-1:0] v;
   int           n;

   // Stages of 1, 2, 4 and 8 enabled by one amount bit each
   always_comb begin
      v = in;
      n = 0;
      for (int k = 0; k < 4; k++) begin
         if (amount[k]) begin
            n = 1 << k;
            case (mode)
               SH_ROL:  v = (v << n) | (v >> (W - n));
               SH_SLL:  v = v << n;              // Zero fill
               SH_ROR:  v = (v >> n) | (v << (W - n));
               default: v = $signed(v) >>> n;   // SRA copies sign bit
            endcase
         end
      end
      out = v;
   end

endmodule

//--- tbChecker.sv
`timescale 1ns/1ps
`include "alu_macros.svh"

module tbChecker (
   input  logic                  clk,
   input  logic                  rstN,
   input  logic                  wbCyc,
   input  logic                  wbStb,
   input  logic                  wbWe,
   input  logic [`ADR_WIDTH-1:0] wbAdr,
   input  logic [`BUS_WIDTH-1:0] wbDatW,
   input  logic [`BUS_WIDTH-1:0] wbDatR,
   input  logic                  wbAck,
   output int                    errCount,
   output int                    checkCount
);
   logic [15:0] modA [`ALU_LANES];
   logic [15:0] modB [`ALU_LANES];
   logic [4:0]  modOp [`ALU_LANES];
   logic        modSign [`ALU_LANES];
   logic [31:0] modRes [`ALU_LANES];   // RESULT word as of the last start
   logic [1:0]  lane;
   logic [1:0]  idx;
   logic [31:0] expected;

   // Reference ALU giving the packed RESULT word with done set
   function automatic logic [31:0] aluModel(input logic [15:0] a, input logic [15:0] b,
                                            input logic [4:0] op, input logic sign);
      logic [16:0] wide;
      logic [15:0] r;
      logic [3:0]  n;
      logic        ofl;
      logic        lt;
      r    = 16'h0;
      ofl  = 1'b0;
      n    = b[3:0];
      wide = {1'b0, a} + {1'b0, b};
      // Flipped sign bits turn a signed order into an unsigned one
      lt   = {a[15] ^ sign, a[14:0]} < {b[15] ^ sign, b[14:0]};
      case (op)
         5'd0: begin
            r   = wide[15:0];
            ofl = sign ? (a[15] == b[15] && r[15] != a[15]) : wide[16];
         end
         5'd1: begin
            r   = b - a;   // B minus A
            ofl = sign ? (a[15] != b[15] && r[15] != b[15]) : (b < a);
         end
         5'd2:  r = a | b;
         5'd3:  r = a & b;
         5'd4:  r = (a << n) | (a >> (16 - n));
         5'd5:  r = a << n;
         5'd6:  r = (a >> n) | (a << (16 - n));
         5'd7:  r = $signed(a) >>> n;
         5'd11: begin
            for (int i = 0; i < 16; i++) r[i] = a[15 - i];
         end
         5'd12: r = {15'b0, a == b};
         5'd13: r = {15'b0, lt};
         5'd14: r = {15'b0, lt || (a == b)};
         5'd15: r = {15'b0, wide[16]};   // Carry only
         5'd19: r = b;
         5'd20: r = {a[7:0], 8'h00} | b;
         default: r = 16'h0;
      endcase
      return {13'b0, 1'b1, r == 16'h0, ofl, r};
   endfunction

   // Bus is stable around the falling edge while ack is high
   always @(negedge clk) begin
      lane = wbAdr[`LANE_MSB:`LANE_LSB];
      idx  = wbAdr[`REG_MSB:`REG_LSB];
      if (!rstN) begin
         for (int l = 0; l < `ALU_LANES; l++) begin
            modA[l]    = 16'h0;
            modB[l]    = 16'h0;
            modOp[l]   = 5'h0;
            modSign[l] = 1'b0;
            modRes[l]  = 32'h0;
         end
         errCount   = 0;
         checkCount = 0;
      end else if (wbCyc && wbStb && wbAck) begin
         if (wbWe) begin
            case (idx)
               2'd0: modA[lane] = wbDatW[15:0];
               2'd1: modB[lane] = wbDatW[15:0];
               2'd2: begin
                  modOp[lane]   = wbDatW[4:0];
                  modSign[lane] = wbDatW[5];
                  modRes[lane]  = aluModel(modA[lane], modB[lane], wbDatW[4:0], wbDatW[5]);
               end
               default: ;   // RESULT ignores writes
            endcase
         end else begin
            case (idx)
               2'd0:    expected = {16'h0, modA[lane]};
               2'd1:    expected = {16'h0, modB[lane]};
               2'd2:    expected = {26'h0, modSign[lane], modOp[lane]};
               default: expected = modRes[lane];
            endcase
            checkCount++;
            if (wbDatR !== expected) begin
               errCount++;
               $display("error wbDatR lane %0d reg %0d: expected %08h, actual %08h",
                        lane, idx, expected, wbDatR);
            end
         end
      end
   end

endmodule

//--- tbClock.sv
`timescale 1ns/1ps

module tbClock #(
   parameter int halfPeriod  = 2,   // 4 ns clock
   parameter int resetCycles = 10
) (
   output logic clk,
   output logic rstN
);
   initial begin
      clk = 1'b0;
      forever #halfPeriod clk = ~clk;
   end

   initial begin
      rstN = 1'b0;
      repeat (resetCycles) @(posedge clk);
      rstN <= 1'b1;
   end

endmodule

//--- wbDispatcher.sv
`timescale 1ns/1ps
`include "alu_macros.svh"

module wbDispatcher import aluPkg::*; (
   input  logic                           clk,
   input  logic                           rstN,
   input  logic                           wbCyc,
   input  logic                           wbStb,
   input  logic                           wbWe,
   input  logic [`ADR_WIDTH-1:0]          wbAdr,
   input  logic [`BUS_WIDTH-1:0]          wbDatW,
   output logic                           wbAck,
   aluLaneIf.dispatch                     lanes [`ALU_LANES],
   output logic                           capture,
   output logic [`LANE_MSB-`LANE_LSB:0]   selLane,
   output laneReg_t                       selReg
);
   localparam int LaneW = `LANE_MSB - `LANE_LSB + 1;

   logic req;
   logic wrReq;

   // New request only while ack is low
   assign req     = wbCyc & wbStb & ~wbAck;
   assign wrReq   = req & wbWe;
   assign capture = req & ~wbWe;
   assign selLane = wbAdr[`LANE_MSB:`LANE_LSB];
   assign selReg  = laneReg_t'(wbAdr[`REG_MSB:`REG_LSB]);

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) wbAck <= 1'b0;
      else       wbAck <= req;
   end

   for (genvar i = 0; i < `ALU_LANES; i++) begin : gLane
      logic   hit;
      logic   ctrlWr;
      aluOp_t opReg;
      logic   signReg;

      assign hit    = wrReq && (selLane == LaneW'(i));
      assign ctrlWr = hit && (selReg == REG_CTRL);

      assign lanes[i].loadA = hit && (selReg == REG_A);
      assign lanes[i].loadB = hit && (selReg == REG_B);
      assign lanes[i].start = ctrlWr;
      assign lanes[i].wdata = wbDatW[`ALU_WIDTH-1:0];
      assign lanes[i].op    = opReg;
      assign lanes[i].sign  = signReg;

      // CTRL fields kept here for the lane's ALU and readback
      always_ff @(posedge clk or negedge rstN) begin
         if (!rstN) begin
            opReg   <= ADD;
            signReg <= 1'b0;
         end else if (ctrlWr) begin
            opReg   <= aluOp_t'(wbDatW[4:0]);
            signReg <= wbDatW[`SIGN_BIT];
         end
      end
   end

endmodule
